/* verilog/bht_pkg.sv */
// Branch history table definitions
// Default table size, the per-entry way vector and the states of the
// initialization sweep

`default_nettype none

package bht_pkg;

   // Default entry index width, giving 512 entries
   localparam int BHT_ADDR_W = 9;

   // Prediction bits held in one entry
   localparam int BHT_WAYS = 4;

   // One entry's content, or a mask that selects ways of an entry
   typedef logic [BHT_WAYS-1:0] bht_ways_t;

   // Sweep FSM, idle or clearing one entry per cycle
   typedef enum logic [0:0] {
      INIT_IDLE  = 1'b0,
      INIT_SWEEP = 1'b1
   } bht_init_state_t;

endpackage

`default_nettype wire

/* verilog/bht_port_ctrl.sv */
// Branch history table port controller
// Arbitrates the write port, the read port and the initialization sweep
// onto the array. A write and a read to the same entry at the same edge
// is a collision. The array write is then dropped and the written bit is
// handed to the read stage as a bypass one cycle later.

`timescale 1ns/10ps
`default_nettype none

module bht_port_ctrl #(
   parameter int ADDR_W = bht_pkg::BHT_ADDR_W
) (
   input  logic               nclk,
   input  logic               rst_n,
   input  logic               init_start,
   input  bht_pkg::bht_ways_t wr_act,
   input  logic [ADDR_W-1:0]  wr_addr,
   input  logic               wr_bit,
   input  logic               rd_act,
   input  logic [ADDR_W-1:0]  rd_addr,
   output logic               init_busy,
   output logic               ary_wr_en,
   output logic [ADDR_W-1:0]  ary_wr_addr,
   output bht_pkg::bht_ways_t ary_wr_mask,
   output bht_pkg::bht_ways_t ary_wr_ways,
   output logic               ary_rd_en,
   output logic [ADDR_W-1:0]  ary_rd_addr,
   output bht_pkg::bht_ways_t byp_ways,
   output logic               byp_bit,
   output logic               rd_pending
);

   import bht_pkg::*;

   bht_init_state_t   init_state;
   logic [ADDR_W-1:0] init_addr;
   logic              sweeping;
   logic              last_entry;

   logic              wr_req;
   logic              rd_req;
   logic              collide;

   assign sweeping   = (init_state == INIT_SWEEP);
   assign last_entry = (init_addr == '1);
   assign init_busy  = sweeping;

   // The sweep FSM clears one entry per cycle until the counter wraps
   always_ff @(posedge nclk) begin
      if (!rst_n) begin
         init_state <= INIT_IDLE;
         init_addr  <= '0;
      end else begin
         case (init_state)
            INIT_IDLE: begin
               if (init_start) begin
                  init_state <= INIT_SWEEP;
                  init_addr  <= '0;
               end
            end
            INIT_SWEEP: begin
               init_addr <= init_addr + ADDR_W'(1);
               if (last_entry) begin
                  init_state <= INIT_IDLE;
               end
            end
            default: begin
               init_state <= INIT_IDLE;
            end
         endcase
      end
   end

   // Requests are only taken while no sweep is running
   assign wr_req  = (|wr_act) && !sweeping;
   assign rd_req  = rd_act && !sweeping;
   assign collide = wr_req && rd_req && (wr_addr == rd_addr);

   // The sweep owns the write port and forces a full-mask zero write
   assign ary_wr_en   = sweeping || (wr_req && !collide);
   assign ary_wr_addr = sweeping ? init_addr : wr_addr;
   assign ary_wr_mask = sweeping ? '1 : wr_act;
   assign ary_wr_ways = sweeping ? '0 : {BHT_WAYS{wr_bit}};

   assign ary_rd_en   = rd_req;
   assign ary_rd_addr = rd_addr;

   always_ff @(posedge nclk) begin
      if (!rst_n) begin
         rd_pending <= 1'b0;
         byp_ways   <= '0;
      end else begin
         rd_pending <= rd_req;
         byp_ways   <= collide ? wr_act : '0;
      end
   end

   // Written bit of a colliding write, only looked at where byp_ways is set
   always_ff @(posedge nclk) begin
      if (collide) begin
         byp_bit <= wr_bit;
      end
   end

   // A finished sweep has wrapped the counter back to the first entry
   a_idle_addr_zero : assert property (
      @(posedge nclk) disable iff (!rst_n)
      !sweeping |-> (init_addr == '0)
   ) else $error("sweep counter not at entry zero while idle");

endmodule

`default_nettype wire

/* verilog/bht_array.sv */
// Branch history table storage array
// One entry per index, each entry holding the ways of one prediction.
// Writes update only the ways selected by the mask. The read port is
// registered and keeps its last value when no read is requested.

`timescale 1ns/10ps
`default_nettype none

module bht_array #(
   parameter int ADDR_W = bht_pkg::BHT_ADDR_W
) (
   input  logic               nclk,
   input  logic               ary_wr_en,
   input  logic [ADDR_W-1:0]  ary_wr_addr,
   input  bht_pkg::bht_ways_t ary_wr_mask,
   input  bht_pkg::bht_ways_t ary_wr_ways,
   input  logic               ary_rd_en,
   input  logic [ADDR_W-1:0]  ary_rd_addr,
   output bht_pkg::bht_ways_t ary_rd_data
);

   import bht_pkg::*;

   localparam int DEPTH = 2 ** ADDR_W;

   bht_ways_t mem [DEPTH];
   bht_ways_t wr_merged;

   // Ways outside the mask keep their stored value
   assign wr_merged = (mem[ary_wr_addr] & ~ary_wr_mask) |
                      (ary_wr_ways & ary_wr_mask);

   always_ff @(posedge nclk) begin
      if (ary_wr_en) begin
         mem[ary_wr_addr] <= wr_merged;
      end
   end

   always_ff @(posedge nclk) begin
      if (ary_rd_en) begin
         ary_rd_data <= mem[ary_rd_addr];
      end
   end

   // The controller resolves same-entry accesses before they get here
   a_no_rw_same_entry : assert property (
      @(posedge nclk)
      !(ary_wr_en && ary_rd_en && (ary_wr_addr == ary_rd_addr))
   ) else $error("read and write to the same entry at one edge");

endmodule

`default_nettype wire

/* verilog/bht_read_stage.sv */
// Branch history table read output stage
// Merges the array read data with the write-through bypass of a
// colliding write and registers the result. The output holds its value
// between reads.

`timescale 1ns/10ps
`default_nettype none

module bht_read_stage (
   input  logic               nclk,
   input  logic               rst_n,
   input  bht_pkg::bht_ways_t ary_rd_data,
   input  bht_pkg::bht_ways_t byp_ways,
   input  logic               byp_bit,
   input  logic               rd_pending,
   output bht_pkg::bht_ways_t rd_ways
);

   import bht_pkg::*;

   bht_ways_t byp_data;
   bht_ways_t ary_kept;
   bht_ways_t rd_next;

   // Bypassed ways take the written bit, the rest come from the array
   assign byp_data = byp_ways & {BHT_WAYS{byp_bit}};
   assign ary_kept = ary_rd_data & ~byp_ways;
   assign rd_next  = byp_data | ary_kept;

   always_ff @(posedge nclk) begin
      if (!rst_n) begin
         rd_ways <= '0;
      end else if (rd_pending) begin
         rd_ways <= rd_next;
      end
   end

   // A bypass only ever comes with an accepted read
   a_byp_needs_read : assert property (
      @(posedge nclk) disable iff (!rst_n)
      !rd_pending |-> (byp_ways == '0)
   ) else $error("bypass mask set without a pending read");

endmodule

`default_nettype wire

/* verilog/bht_top.sv */
// Branch history table, one read and one write port
// Each entry holds four one-bit ways. Reads return all ways of an entry
// one cycle after the read edge; writes set one bit in any subset of
// ways. A pulse on init_start clears the whole table, one entry per
// cycle, while init_busy is high.

`timescale 1ns/10ps
`default_nettype none

module bht_top #(
   parameter int ADDR_W = bht_pkg::BHT_ADDR_W
) (
   input  logic               nclk,
   input  logic               rst_n,
   input  logic               init_start,
   input  bht_pkg::bht_ways_t wr_act,
   input  logic [ADDR_W-1:0]  wr_addr,
   input  logic               wr_bit,
   input  logic               rd_act,
   input  logic [ADDR_W-1:0]  rd_addr,
   output logic               init_busy,
   output bht_pkg::bht_ways_t rd_ways
);

   import bht_pkg::*;

   logic              ary_wr_en;
   logic [ADDR_W-1:0] ary_wr_addr;
   bht_ways_t         ary_wr_mask;
   bht_ways_t         ary_wr_ways;
   logic              ary_rd_en;
   logic [ADDR_W-1:0] ary_rd_addr;
   bht_ways_t         ary_rd_data;

   bht_ways_t         byp_ways;
   logic              byp_bit;
   logic              rd_pending;

   bht_port_ctrl #(
      .ADDR_W(ADDR_W)
   ) ctrl_i (
      .nclk        (nclk),
      .rst_n       (rst_n),
      .init_start  (init_start),
      .wr_act      (wr_act),
      .wr_addr     (wr_addr),
      .wr_bit      (wr_bit),
      .rd_act      (rd_act),
      .rd_addr     (rd_addr),
      .init_busy   (init_busy),
      .ary_wr_en   (ary_wr_en),
      .ary_wr_addr (ary_wr_addr),
      .ary_wr_mask (ary_wr_mask),
      .ary_wr_ways (ary_wr_ways),
      .ary_rd_en   (ary_rd_en),
      .ary_rd_addr (ary_rd_addr),
      .byp_ways    (byp_ways),
      .byp_bit     (byp_bit),
      .rd_pending  (rd_pending)
   );

   bht_array #(
      .ADDR_W(ADDR_W)
   ) array_i (
      .nclk        (nclk),
      .ary_wr_en   (ary_wr_en),
      .ary_wr_addr (ary_wr_addr),
      .ary_wr_mask (ary_wr_mask),
      .ary_wr_ways (ary_wr_ways),
      .ary_rd_en   (ary_rd_en),
      .ary_rd_addr (ary_rd_addr),
      .ary_rd_data (ary_rd_data)
   );

   bht_read_stage read_i (
      .nclk        (nclk),
      .rst_n       (rst_n),
      .ary_rd_data (ary_rd_data),
      .byp_ways    (byp_ways),
      .byp_bit     (byp_bit),
      .rd_pending  (rd_pending),
      .rd_ways     (rd_ways)
   );

endmodule

`default_nettype wire

/* test/bht_checker.sv */
// Branch history table checker
// Keeps a model of the table and of the read pipeline. The model steps at
// every clock edge on the inputs the DUT samples there, and init_busy and
// rd_ways are compared against it before the edge updates them.

`timescale 1ns/10ps
`default_nettype none

module bht_checker #(
   parameter int ADDR_W = bht_pkg::BHT_ADDR_W
) (
   input  logic               nclk,
   input  logic               rst_n,
   input  logic [2:0]         test_id,
   input  logic               init_start,
   input  bht_pkg::bht_ways_t wr_act,
   input  logic [ADDR_W-1:0]  wr_addr,
   input  logic               wr_bit,
   input  logic               rd_act,
   input  logic [ADDR_W-1:0]  rd_addr,
   input  logic               init_busy,
   input  bht_pkg::bht_ways_t rd_ways,
   output int                 err_count
);

   import bht_pkg::*;

   localparam int DEPTH = 2 ** ADDR_W;

   bht_ways_t         model [DEPTH];
   logic              known [DEPTH];
   logic              busy_m;
   logic [ADDR_W-1:0] sweep_addr;
   logic              pend;
   bht_ways_t         pend_val;
   logic              pend_known;
   bht_ways_t         exp_rd;
   logic              exp_known;
   int                errors = 0;

   assign err_count = errors;

   function automatic string test_name(input logic [2:0] id);
      case (id)
         3'd1:    return "sweep";
         3'd2:    return "masked_write";
         3'd3:    return "collision";
         3'd4:    return "hold";
         3'd5:    return "busy";
         default: return "reset";
      endcase
   endfunction

   // A written bit of one sets the masked ways, a bit of zero clears them
   function automatic bht_ways_t apply_write(input bht_ways_t old, input bht_ways_t mask,
                                             input logic value);
      return value ? (old | mask) : (old & ~mask);
   endfunction

   always @(posedge nclk) begin : step_model
      logic wr_ok;
      logic rd_ok;
      logic collide;
      if (!rst_n) begin
         busy_m     = 1'b0;
         sweep_addr = '0;
         pend       = 1'b0;
         pend_val   = '0;
         pend_known = 1'b0;
         exp_rd     = '0;
         exp_known  = 1'b1;
         known      = '{default: 1'b0};
      end else begin
         if (init_busy !== busy_m) begin
            $display("ERR %s init_busy expected %0b actual %0b",
                     test_name(test_id), busy_m, init_busy);
            errors++;
         end
         if (exp_known && (rd_ways !== exp_rd)) begin
            $display("ERR %s rd_ways expected %h actual %h",
                     test_name(test_id), exp_rd, rd_ways);
            errors++;
         end

         // The output register takes the read accepted one edge earlier
         if (pend) begin
            exp_rd    = pend_val;
            exp_known = pend_known;
         end

         wr_ok   = !busy_m && (wr_act != '0);
         rd_ok   = !busy_m && rd_act;
         collide = wr_ok && rd_ok && (wr_addr == rd_addr);
         pend    = rd_ok;
         if (rd_ok) begin
            pend_known = known[rd_addr];
            pend_val   = collide ? apply_write(model[rd_addr], wr_act, wr_bit)
                                 : model[rd_addr];
         end
         if (wr_ok && !collide && (known[wr_addr] || (wr_act == '1))) begin
            model[wr_addr] = apply_write(model[wr_addr], wr_act, wr_bit);
            known[wr_addr] = 1'b1;
         end

         if (busy_m) begin
            model[sweep_addr] = '0;
            known[sweep_addr] = 1'b1;
            if (sweep_addr == '1) begin
               busy_m = 1'b0;
            end
            sweep_addr = sweep_addr + 1'b1;
         end else if (init_start) begin
            busy_m     = 1'b1;
            sweep_addr = '0;
         end
      end
   end

endmodule

`default_nettype wire

/* test/bht_tb.sv */
// Branch history table testbench
// Drives sweeps, random masked writes, collisions, idle stretches and
// requests during a sweep into a 16-entry table. The checker compares
// every cycle against its model; the run ends with an error summary.

`timescale 1ns/10ps
`default_nettype none

module bht_tb;

   import bht_pkg::*;

   localparam int TB_ADDR_W   = 4;
   localparam int DEPTH       = 2 ** TB_ADDR_W;
   localparam int SEED        = 32'h23f2;
   localparam int RAND_CYCLES = 200;

   logic                 nclk;
   logic                 rst_n;
   logic                 init_start;
   bht_ways_t            wr_act;
   logic [TB_ADDR_W-1:0] wr_addr;
   logic                 wr_bit;
   logic                 rd_act;
   logic [TB_ADDR_W-1:0] rd_addr;
   logic                 init_busy;
   bht_ways_t            rd_ways;
   logic [2:0]           test_id;
   int                   chk_errors;
   int                   tb_errors;

   always #5 nclk = ~nclk;

   bht_top #(
      .ADDR_W(TB_ADDR_W)
   ) dut_i (
      .nclk       (nclk),
      .rst_n      (rst_n),
      .init_start (init_start),
      .wr_act     (wr_act),
      .wr_addr    (wr_addr),
      .wr_bit     (wr_bit),
      .rd_act     (rd_act),
      .rd_addr    (rd_addr),
      .init_busy  (init_busy),
      .rd_ways    (rd_ways)
   );

   bht_checker #(
      .ADDR_W(TB_ADDR_W)
   ) chk_i (
      .nclk       (nclk),
      .rst_n      (rst_n),
      .test_id    (test_id),
      .init_start (init_start),
      .wr_act     (wr_act),
      .wr_addr    (wr_addr),
      .wr_bit     (wr_bit),
      .rd_act     (rd_act),
      .rd_addr    (rd_addr),
      .init_busy  (init_busy),
      .rd_ways    (rd_ways),
      .err_count  (chk_errors)
   );

   function automatic logic [TB_ADDR_W-1:0] rand_addr();
      logic [31:0] r;
      r = $urandom();
      return r[TB_ADDR_W-1:0];
   endfunction

   function automatic bht_ways_t rand_mask();
      logic [31:0] r;
      r = $urandom();
      return r[BHT_WAYS-1:0];
   endfunction

   function automatic logic rand_bit();
      logic [31:0] r;
      r = $urandom();
      return r[0];
   endfunction

   // Assigns all request inputs without waiting for a clock edge
   task automatic set_req(input bht_ways_t mask, input logic [TB_ADDR_W-1:0] waddr,
                          input logic wbit, input logic ract,
                          input logic [TB_ADDR_W-1:0] raddr, input logic start);
      wr_act     <= mask;
      wr_addr    <= waddr;
      wr_bit     <= wbit;
      rd_act     <= ract;
      rd_addr    <= raddr;
      init_start <= start;
   endtask

   task automatic step_req(input bht_ways_t mask, input logic [TB_ADDR_W-1:0] waddr,
                           input logic wbit, input logic ract,
                           input logic [TB_ADDR_W-1:0] raddr);
      @(posedge nclk);
      set_req(mask, waddr, wbit, ract, raddr, 1'b0);
   endtask

   task automatic step_idle();
      step_req('0, '0, 1'b0, 1'b0, '0);
   endtask

   task automatic step_random();
      step_req(rand_mask(), rand_addr(), rand_bit(), rand_bit(), rand_addr());
   endtask

   task automatic read_all();
      for (int i = 0; i < DEPTH; i++) begin
         step_req('0, '0, 1'b0, 1'b1, TB_ADDR_W'(i));
      end
      step_idle();
      step_idle();
   endtask

   // Pulses init_start and waits for init_busy to rise and fall. With
   // noisy set, random requests (and early restarts) hit the busy table.
   task automatic run_sweep(input logic noisy);
      int   waited;
      int   busy_cycles;
      logic done;
      logic start;
      @(posedge nclk);
      set_req('0, '0, 1'b0, 1'b0, '0, 1'b1);
      @(posedge nclk);
      set_req('0, '0, 1'b0, 1'b0, '0, 1'b0);
      waited = 0;
      @(negedge nclk);
      while (!init_busy && (waited < 8)) begin
         @(negedge nclk);
         waited++;
      end
      if (!init_busy) begin
         $display("init_busy never rose after an init_start pulse");
         tb_errors++;
      end else begin
         busy_cycles = 1;
         done        = 1'b0;
         while (!done && (busy_cycles <= DEPTH + 8)) begin
            @(posedge nclk);
            if (noisy) begin
               start = (busy_cycles < DEPTH - 1) && (rand_mask() == '0);
               set_req(rand_mask(), rand_addr(), rand_bit(), rand_bit(), rand_addr(), start);
            end else begin
               set_req('0, '0, 1'b0, 1'b0, '0, 1'b0);
            end
            @(negedge nclk);
            if (init_busy) begin
               busy_cycles++;
            end else begin
               done = 1'b1;
            end
         end
         if (!done) begin
            $display("init_busy stayed high long after the sweep should have ended");
            tb_errors++;
         end
      end
      step_idle();
   endtask

   initial begin
      logic [TB_ADDR_W-1:0] addr;
      bht_ways_t            mask;
      logic                 wbit;
      nclk       = 1'b0;
      rst_n      = 1'b0;
      init_start = 1'b0;
      wr_act     = '0;
      wr_addr    = '0;
      wr_bit     = 1'b0;
      rd_act     = 1'b0;
      rd_addr    = '0;
      test_id    = 3'd0;
      tb_errors  = 0;
      void'($urandom(SEED));

      repeat (5) @(posedge nclk);
      rst_n   <= 1'b1;
      test_id <= 3'd1;
      step_idle();
      run_sweep(1'b0);
      read_all();

      test_id <= 3'd2;
      repeat (RAND_CYCLES) step_random();
      step_idle();
      read_all();

      test_id <= 3'd3;
      repeat (40) begin
         addr = rand_addr();
         mask = rand_mask();
         if (mask == '0) begin
            mask[0] = 1'b1;
         end
         step_req(mask, addr, rand_bit(), 1'b1, addr);
         step_req('0, '0, 1'b0, 1'b1, addr);
      end
      step_idle();

      // The colliding read leaves rd_ways unlike the array's read data,
      // and only writes follow it
      test_id <= 3'd4;
      addr = rand_addr();
      wbit = rand_bit();
      step_req(4'hf, addr, wbit, 1'b0, '0);
      step_req(4'hf, addr, ~wbit, 1'b1, addr);
      repeat (20) step_req(rand_mask(), rand_addr(), rand_bit(), 1'b0, rand_addr());
      step_idle();

      test_id <= 3'd5;
      repeat (30) step_random();
      step_req('0, '0, 1'b0, 1'b1, rand_addr());
      run_sweep(1'b1);
      read_all();

      repeat (3) step_idle();
      @(negedge nclk);
      $display("errors: checker %0d testbench %0d", chk_errors, tb_errors);
      if ((chk_errors == 0) && (tb_errors == 0)) begin
         $display("all tests passed");
      end else begin
         $display("tests failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* project.f */
verilog/bht_pkg.sv
verilog/bht_port_ctrl.sv
verilog/bht_array.sv
verilog/bht_read_stage.sv
verilog/bht_top.sv
test/bht_checker.sv
test/bht_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= bht_tb
SEED_ARGS ?= +verilator+seed+9202
VFLAGS    ?= --binary --assert

FILELIST := project.f
SRCS     := $(filter %.sv %.v,$(shell cat $(FILELIST)))
SIM      := obj_dir/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM) $(SEED_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "all tests passed"

clean:
	rm -rf obj_dir
